// File: Makefile
SIM := obj_dir/VfrontDecodeTb
SRCS := $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module frontDecodeTb

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+hw
hw/mipsIsaPkg.sv
hw/pipeStagePkg.sv
hw/instrDecoder.sv
hw/decodeStage.sv
hw/fetchDecodeLatch.sv
hw/frontDecodeTop.sv
dv/frontDecode_assert.sv
dv/frontDecodeTb.sv

// File: dv/frontDecodeTb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module frontDecodeTb;

    import mipsIsaPkg::*;
    import pipeStagePkg::*;

    // cycle cap for the whole run
    localparam int MAX_CYCLES = 400;

    logic clk;
    logic rstN;
    logic stall;
    logic flush;
    fetchData_t  [`ISSUE_W-1:0] fetchIn;
    decodeData_t [`ISSUE_W-1:0] decodeOut;
    logic jrRa;

    logic [31:0] lfsr;
    int cycles = 0;
    int errors = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    frontDecodeTop DUT (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .flush     (flush),
        .fetchIn   (fetchIn),
        .decodeOut (decodeOut),
        .jrRa      (jrRa)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit taken
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // instruction builders with random register and imm fields
    function automatic instr_t rType(logic [5:0] fn);
        return {6'h00, 20'(randBits(20)), fn};
    endfunction

    function automatic instr_t iType(logic [5:0] op);
        return {op, 26'(randBits(26))};
    endfunction

    function automatic instr_t jrInstr(logic [4:0] rs);
        return {6'h00, rs, 15'(randBits(15)), 6'h08};
    endfunction

    // mfc0 or mtc0 by the rs format field
    // random rt rd and sel
    function automatic instr_t cop0Move(logic [4:0] fmt);
        return {6'h10, fmt, 10'(randBits(10)), 8'h00, 3'(randBits(3))};
    endfunction

    function automatic fetchData_t makeSlot(logic v, instr_t w);
        fetchData_t f;
        f.valid    = v;
        f.rawInstr = w;
        f.pc       = {30'(randBits(30)), 2'b00};
        f.preB     = 1'(randBits(1));
        f.prePc    = {30'(randBits(30)), 2'b00};
        f.cp0Ctl   = '0;
        return f;
    endfunction

    // aluOp plus eleven flag bits in struct order
    function automatic decodeCtl_t ctlOf(aluOp_e a, logic [10:0] flags);
        return decodeCtl_t'({a, flags});
    endfunction

    // expected decode of one slot
    function automatic decodeData_t refDecode(fetchData_t f, logic older);
        decodeData_t d;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        op = f.rawInstr[31:26];
        fn = f.rawInstr[5:0];
        rs = f.rawInstr[25:21];
        rt = f.rawInstr[20:16];
        rd = f.rawInstr[15:11];
        d = '0;
        d.valid    = f.valid;
        d.rawInstr = f.rawInstr;
        d.pc       = f.pc;
        d.imm      = f.rawInstr[15:0];
        d.cp0ra    = {rd, f.rawInstr[2:0]};
        if (older) begin
            d.preB  = f.preB;
            d.prePc = f.prePc;
        end
        if (!f.valid) begin
            return d;
        end
        d.ra1    = rs;
        d.ra2    = rt;
        d.cp0Ctl = f.cp0Ctl;
        // flag order regWrite memRead memWrite aluSrcImm immSigned branch jump link
        // then cp0Read cp0Write eret
        case (op)
            6'h00: begin
                case (fn)
                    6'h21: d.ctl = ctlOf(ALU_ADD, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h23: d.ctl = ctlOf(ALU_SUB, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h24: d.ctl = ctlOf(ALU_AND, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h25: d.ctl = ctlOf(ALU_OR,  11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h26: d.ctl = ctlOf(ALU_XOR, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h2a: d.ctl = ctlOf(ALU_SLT, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h00: d.ctl = ctlOf(ALU_SLL, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h02: d.ctl = ctlOf(ALU_SRL, 11'b1_0_0_0_0_0_0_0_0_0_0);
                    6'h08: d.ctl = ctlOf(ALU_NOP, 11'b0_0_0_0_0_0_1_0_0_0_0);
                    6'h0c: d.cp0Ctl.syscall = 1'b1;
                    default: d.cp0Ctl.reservedInstr = 1'b1;
                endcase
            end
            6'h09: d.ctl = ctlOf(ALU_ADD, 11'b1_0_0_1_1_0_0_0_0_0_0);
            6'h23: d.ctl = ctlOf(ALU_ADD, 11'b1_1_0_1_1_0_0_0_0_0_0);
            6'h0d: d.ctl = ctlOf(ALU_OR,  11'b1_0_0_1_0_0_0_0_0_0_0);
            6'h0f: d.ctl = ctlOf(ALU_LUI, 11'b1_0_0_1_0_0_0_0_0_0_0);
            6'h2b: d.ctl = ctlOf(ALU_ADD, 11'b0_0_1_1_1_0_0_0_0_0_0);
            6'h04, 6'h05: d.ctl = ctlOf(ALU_SUB, 11'b0_0_0_0_1_1_0_0_0_0_0);
            6'h02: d.ctl = ctlOf(ALU_NOP, 11'b0_0_0_0_0_0_1_0_0_0_0);
            6'h03: d.ctl = ctlOf(ALU_NOP, 11'b1_0_0_0_0_0_1_1_0_0_0);
            6'h10: begin
                if (f.rawInstr[25] && fn == 6'h18) begin
                    d.ctl = ctlOf(ALU_NOP, 11'b0_0_0_0_0_0_0_0_0_0_1);
                end else if (!f.rawInstr[25] && rs == 5'd0) begin
                    d.ctl = ctlOf(ALU_NOP, 11'b1_0_0_0_0_0_0_0_1_0_0);
                end else if (!f.rawInstr[25] && rs == 5'd4) begin
                    d.ctl = ctlOf(ALU_NOP, 11'b0_0_0_0_0_0_0_0_0_1_0);
                end else begin
                    d.cp0Ctl.reservedInstr = 1'b1;
                end
            end
            default: d.cp0Ctl.reservedInstr = 1'b1;
        endcase
        // destination by format
        // zero when nothing is written
        if (d.ctl.regWrite) begin
            if (op == 6'h00) begin
                d.rdst = rd;
            end else if (op == 6'h03) begin
                d.rdst = 5'd31;
            end else begin
                d.rdst = rt;
            end
        end
        return d;
    endfunction

    task automatic checkSlot(string name, int s, decodeData_t exp);
        if (decodeOut[s] !== exp) begin
            $display("Mismatch %s slot %0d: expected %h, actual %h", name, s, exp, decodeOut[s]);
            errors++;
        end
    endtask

    // drive a pair and compare both slots and jrRa after capture
    task automatic runPair(string name, fetchData_t older, fetchData_t younger);
        logic expJr;
        expJr = older.valid && older.rawInstr[31:26] == 6'h00
            && older.rawInstr[5:0] == 6'h08 && older.rawInstr[25:21] == 5'd31;
        @(posedge clk);
        fetchIn[1] <= older;
        fetchIn[0] <= younger;
        @(posedge clk);
        @(negedge clk);
        checkSlot(name, 1, refDecode(older, 1'b1));
        checkSlot(name, 0, refDecode(younger, 1'b0));
        if (jrRa !== expJr) begin
            $display("Mismatch %s jrRa: expected %b, actual %b", name, expJr, jrRa);
            errors++;
        end
    endtask

    task automatic finishTest(string name, int errorsAtStart);
        if (errors == errorsAtStart) begin
            testsPassed++;
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: fail, %0d errors", name, errors - errorsAtStart);
        end
    endtask

    task automatic testRtype();
        int e0;
        e0 = errors;
        runPair("rtype", makeSlot(1, rType(FN_ADDU)), makeSlot(1, rType(FN_SUBU)));
        runPair("rtype", makeSlot(1, rType(FN_AND)), makeSlot(1, rType(FN_OR)));
        runPair("rtype", makeSlot(1, rType(FN_XOR)), makeSlot(1, rType(FN_SLT)));
        runPair("rtype", makeSlot(1, rType(FN_SLL)), makeSlot(1, rType(FN_SRL)));
        finishTest("rtype", e0);
    endtask

    task automatic testImmMem();
        int e0;
        e0 = errors;
        runPair("immMem", makeSlot(1, iType(OP_ADDIU)), makeSlot(1, iType(OP_ORI)));
        runPair("immMem", makeSlot(1, iType(OP_LUI)), makeSlot(1, iType(OP_LW)));
        runPair("immMem", makeSlot(1, iType(OP_SW)), makeSlot(1, iType(OP_ADDIU)));
        finishTest("immMem", e0);
    endtask

    task automatic testControl();
        int e0;
        e0 = errors;
        runPair("control", makeSlot(1, iType(OP_BEQ)), makeSlot(1, iType(OP_BNE)));
        runPair("control", makeSlot(1, iType(OP_J)), makeSlot(1, iType(OP_JAL)));
        // return in the older slot and plain jr in the younger
        runPair("control", makeSlot(1, jrInstr(5'd31)), makeSlot(1, jrInstr(5'(randBits(5)))));
        // return in the younger slot must not raise jrRa
        runPair("control", makeSlot(1, rType(FN_ADDU)), makeSlot(1, jrInstr(5'd31)));
        finishTest("control", e0);
    endtask

    task automatic testCp0();
        int e0;
        fetchData_t errSlot;
        fetchData_t idleSlot;
        e0 = errors;
        runPair("cp0", makeSlot(1, cop0Move(5'd0)), makeSlot(1, cop0Move(5'd4)));
        runPair("cp0", makeSlot(1, 32'h4200_0018), makeSlot(1, rType(FN_SYSCALL)));
        // fetch address error carried through decode
        errSlot = makeSlot(1, rType(FN_ADDU));
        errSlot.cp0Ctl.fetchAddrErr = 1'b1;
        runPair("cp0", makeSlot(1, {6'h3f, 26'(randBits(26))}), errSlot);
        // empty older slot with a return and an error shows nothing
        idleSlot = makeSlot(0, jrInstr(5'd31));
        idleSlot.cp0Ctl.fetchAddrErr = 1'b1;
        runPair("cp0", idleSlot, makeSlot(0, rType(FN_SYSCALL)));
        finishTest("cp0", e0);
    endtask

    task automatic testLatch();
        int e0;
        fetchData_t a1;
        fetchData_t a0;
        fetchData_t c1;
        fetchData_t c0;
        e0 = errors;
        a1 = makeSlot(1, rType(FN_OR));
        a0 = makeSlot(1, iType(OP_LW));
        c1 = makeSlot(1, iType(OP_ORI));
        c0 = makeSlot(1, cop0Move(5'd0));
        // fetch offered a valid pair with a return all through reset
        @(negedge clk);
        if (decodeOut[1].valid || decodeOut[0].valid || jrRa) begin
            $display("slots are valid or jrRa is high right after reset");
            errors++;
        end
        runPair("latch", a1, a0);
        // stall two cycles while fetch offers a different pair
        @(posedge clk);
        stall <= 1'b1;
        fetchIn[1] <= makeSlot(1, iType(OP_SW));
        fetchIn[0] <= makeSlot(1, rType(FN_XOR));
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkSlot("latch stall", 1, refDecode(a1, 1'b1));
        checkSlot("latch stall", 0, refDecode(a0, 1'b0));
        // flush wins over stall
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (decodeOut[1].valid || decodeOut[0].valid) begin
            $display("Mismatch latch flush: expected valid 00, actual %b%b",
                     decodeOut[1].valid, decodeOut[0].valid);
            errors++;
        end
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        fetchIn[1] <= c1;
        fetchIn[0] <= c0;
        // nothing may show before capture
        @(negedge clk);
        if (decodeOut[1].valid || decodeOut[0].valid) begin
            $display("new pair showed up before the latch captured it");
            errors++;
        end
        @(posedge clk);
        @(negedge clk);
        checkSlot("latch release", 1, refDecode(c1, 1'b1));
        checkSlot("latch release", 0, refDecode(c0, 1'b0));
        finishTest("latch", e0);
    endtask

    initial begin
        lfsr       = 32'hbff2;
        rstN       = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        // valid pair with jr $31 in the older slot, reset has to drop it
        fetchIn[1] = makeSlot(1, jrInstr(5'd31));
        fetchIn[0] = makeSlot(1, rType(FN_ADDU));
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        testLatch();
        testRtype();
        testImmMem();
        testControl();
        testCp0();
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 testsPassed, testsFailed, errors);
        if (testsFailed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dv/frontDecode_assert.sv
`timescale 1ns/1ps
`include "core_params.svh"

module frontDecodeAssert (
    input logic                                     clk,
    input logic                                     rstN,
    input logic                                     stall,
    input logic                                     flush,
    input pipeStagePkg::decodeData_t [`ISSUE_W-1:0] decodeOut,
    input logic                                     jrRa
);

    // reset or flush empties both slots next cycle
    clearOnFlush: assert property (@(posedge clk)
        (!rstN || flush) |=> (!decodeOut[1].valid && !decodeOut[0].valid))
        else $error("decode pair still valid after reset or flush");

    // held pair must not move while stalled
    holdOnStall: assert property (@(posedge clk)
        (rstN && !flush && stall) |=> $stable(decodeOut))
        else $error("decode pair changed during stall");

    // younger slot never carries a prediction
    noYoungPred: assert property (@(posedge clk) !decodeOut[0].preB)
        else $error("slot 0 shows a branch prediction");

    // return flag only from a live older slot
    jrRaValid: assert property (@(posedge clk) jrRa |-> decodeOut[1].valid)
        else $error("jrRa high with slot 1 empty");

endmodule

bind frontDecodeTop frontDecodeAssert uAssert (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .flush     (flush),
    .decodeOut (decodeOut),
    .jrRa      (jrRa)
);

// File: hw/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and pc width
`define DATA_W 32

// gpr index width, 32 registers
`define REG_ADDR_W 5

// issue slots per fetch pair
// slot 1 is the older instruction, slot 0 the younger
`define ISSUE_W 2

`endif

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decodeStage (
    input  pipeStagePkg::fetchData_t  [`ISSUE_W-1:0] dataF2,
    output pipeStagePkg::decodeData_t [`ISSUE_W-1:0] dataD,
    output logic                                     jrRa
);

    // per slot jr $ra flags, only the older one leaves
    logic [`ISSUE_W-1:0] slotJrRa;

    for (genvar i = 0; i < `ISSUE_W; ++i) begin : gSlot
        instrDecoder uDecoder (
            .valid     (dataF2[i].valid),
            .instr     (dataF2[i].rawInstr),
            .cp0CtlOld (dataF2[i].cp0Ctl),
            .ctl       (dataD[i].ctl),
            .cp0Ctl    (dataD[i].cp0Ctl),
            .srcRegA   (dataD[i].ra1),
            .srcRegB   (dataD[i].ra2),
            .destReg   (dataD[i].rdst),
            .isJrRa    (slotJrRa[i])
        );

        // raw fields straight from the word
        assign dataD[i].valid    = dataF2[i].valid;
        assign dataD[i].rawInstr = dataF2[i].rawInstr;
        assign dataD[i].pc       = dataF2[i].pc;
        assign dataD[i].imm      = dataF2[i].rawInstr[15:0];
        // cp0 index {rd, sel}
        assign dataD[i].cp0ra    = {dataF2[i].rawInstr[15:11], dataF2[i].rawInstr[2:0]};

        // predictor fields belong to the older slot only
        if (i == `ISSUE_W-1) begin : gOlder
            assign dataD[i].preB  = dataF2[i].preB;
            assign dataD[i].prePc = dataF2[i].prePc;
        end else begin : gYounger
            assign dataD[i].preB  = 1'b0;
            assign dataD[i].prePc = '0;
        end
    end

    // ras only consults the older slot
    assign jrRa = slotJrRa[`ISSUE_W-1];

endmodule

// File: hw/fetchDecodeLatch.sv
`timescale 1ns/1ps
`include "core_params.svh"

module fetchDecodeLatch (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    stall,
    input  logic                                    flush,
    input  pipeStagePkg::fetchData_t [`ISSUE_W-1:0] fetchIn,
    output pipeStagePkg::fetchData_t [`ISSUE_W-1:0] dataF2
);

    // fetch/decode pipeline register
    // flush beats stall, stall beats load
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            // drop the pair, payload left as is
            for (int i = 0; i < `ISSUE_W; i++) begin
                dataF2[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            dataF2 <= fetchIn;
        end
        // stall high, hold the pair
    end

endmodule

// File: hw/frontDecodeTop.sv
`timescale 1ns/1ps
`include "core_params.svh"

module frontDecodeTop (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  logic                                     stall,
    input  logic                                     flush,
    input  pipeStagePkg::fetchData_t  [`ISSUE_W-1:0] fetchIn,
    output pipeStagePkg::decodeData_t [`ISSUE_W-1:0] decodeOut,
    output logic                                     jrRa
);

    // registered pair feeding decode
    pipeStagePkg::fetchData_t [`ISSUE_W-1:0] latchedF2;

    // one cycle from fetch to decoded pair
    fetchDecodeLatch uLatch (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .fetchIn (fetchIn),
        .dataF2  (latchedF2)
    );

    // combinational decode of the held pair
    decodeStage uDecode (
        .dataF2 (latchedF2),
        .dataD  (decodeOut),
        .jrRa   (jrRa)
    );

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic                    valid,
    input  mipsIsaPkg::instr_t      instr,
    input  pipeStagePkg::cp0Ctl_t   cp0CtlOld,
    output pipeStagePkg::decodeCtl_t ctl,
    output pipeStagePkg::cp0Ctl_t   cp0Ctl,
    output mipsIsaPkg::regAddr_t    srcRegA,
    output mipsIsaPkg::regAddr_t    srcRegB,
    output mipsIsaPkg::regAddr_t    destReg,
    output logic                    isJrRa
);

    import mipsIsaPkg::*;
    import pipeStagePkg::*;

    opcode_e    opcode;
    funct_e     funct;
    regAddr_t   rs;
    regAddr_t   rt;
    regAddr_t   rd;
    decodeCtl_t ctlRaw;
    cp0Ctl_t    cp0New;
    regAddr_t   destRaw;

    // instruction fields
    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        // default is a nop writing nothing
        ctlRaw       = '0;
        cp0New       = '0;
        destRaw      = '0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU:    ctlRaw.aluOp = ALU_ADD;
                    FN_SUBU:    ctlRaw.aluOp = ALU_SUB;
                    FN_AND:     ctlRaw.aluOp = ALU_AND;
                    FN_OR:      ctlRaw.aluOp = ALU_OR;
                    FN_XOR:     ctlRaw.aluOp = ALU_XOR;
                    FN_SLT:     ctlRaw.aluOp = ALU_SLT;
                    FN_SLL:     ctlRaw.aluOp = ALU_SLL;
                    FN_SRL:     ctlRaw.aluOp = ALU_SRL;
                    FN_JR:      ctlRaw.jump = 1'b1;
                    FN_SYSCALL: cp0New.syscall = 1'b1;
                    default:    cp0New.reservedInstr = 1'b1;
                endcase
                // every alu funct writes rd
                if (ctlRaw.aluOp != ALU_NOP) begin
                    ctlRaw.regWrite = 1'b1;
                    destRaw         = rd;
                end
            end
            OP_ADDIU, OP_LW: begin
                ctlRaw.aluOp     = ALU_ADD;
                ctlRaw.regWrite  = 1'b1;
                ctlRaw.aluSrcImm = 1'b1;
                ctlRaw.immSigned = 1'b1;
                ctlRaw.memRead   = (opcode == OP_LW);
                destRaw          = rt;
            end
            OP_ORI, OP_LUI: begin
                // logical imm forms zero extend
                ctlRaw.aluOp     = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                ctlRaw.regWrite  = 1'b1;
                ctlRaw.aluSrcImm = 1'b1;
                destRaw          = rt;
            end
            OP_SW: begin
                // address add, no register result
                ctlRaw.aluOp     = ALU_ADD;
                ctlRaw.memWrite  = 1'b1;
                ctlRaw.aluSrcImm = 1'b1;
                ctlRaw.immSigned = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // compare by subtract, signed offset
                ctlRaw.aluOp     = ALU_SUB;
                ctlRaw.branch    = 1'b1;
                ctlRaw.immSigned = 1'b1;
            end
            OP_J: ctlRaw.jump = 1'b1;
            OP_JAL: begin
                ctlRaw.jump     = 1'b1;
                ctlRaw.link     = 1'b1;
                ctlRaw.regWrite = 1'b1;
                // $ra is r31, all ones
                destRaw         = '1;
            end
            OP_COP0: begin
                if (instr[25]) begin
                    // CO format, only eret supported
                    if (funct == FN_ERET) begin
                        ctlRaw.eret = 1'b1;
                    end else begin
                        cp0New.reservedInstr = 1'b1;
                    end
                end else begin
                    case (cop0Fmt_e'(rs))
                        C0_MF: begin
                            ctlRaw.cp0Read  = 1'b1;
                            ctlRaw.regWrite = 1'b1;
                            destRaw         = rt;
                        end
                        C0_MT:   ctlRaw.cp0Write = 1'b1;
                        default: cp0New.reservedInstr = 1'b1;
                    endcase
                end
            end
            default: cp0New.reservedInstr = 1'b1;
        endcase
    end

    // an empty slot shows nothing at all
    assign ctl     = valid ? ctlRaw : '0;
    assign cp0Ctl  = valid ? cp0Ctl_t'(cp0CtlOld | cp0New) : '0;
    assign srcRegA = valid ? rs : '0;
    assign srcRegB = valid ? rt : '0;
    assign destReg = valid ? destRaw : '0;

    // jr $31, a return for the ras
    assign isJrRa = valid && (opcode == OP_SPECIAL) && (funct == FN_JR) && (&rs);

endmodule

// File: hw/mipsIsaPkg.sv
`include "core_params.svh"

package mipsIsaPkg;

    // plain machine words
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`DATA_W-1:0] instr_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;
    // cp0 index is {rd, sel}
    typedef logic [7:0] cp0Addr_t;
    typedef logic [15:0] imm_t;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // SPECIAL functs, instr[5:0]
    // FN_ERET only meaningful under COP0 with the CO bit set
    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_ERET    = 6'h18,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_SLT     = 6'h2a
    } funct_e;

    // cop0 move formats, rs field
    typedef enum logic [4:0] {
        C0_MF = 5'b00000,
        C0_MT = 5'b00100
    } cop0Fmt_e;

    // zero encoding is nop so a cleared bundle does nothing
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_LUI = 4'd9
    } aluOp_e;

endpackage

// File: hw/pipeStagePkg.sv
package pipeStagePkg;

    import mipsIsaPkg::*;

    // decoded control for one instruction
    typedef struct packed {
        aluOp_e aluOp;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        // second operand from imm instead of rt
        logic   aluSrcImm;
        // sign extend imm, else zero extend
        logic   immSigned;
        logic   branch;
        logic   jump;
        // writes return address
        logic   link;
        logic   cp0Read;
        logic   cp0Write;
        logic   eret;
    } decodeCtl_t;

    // exception flags headed for cp0
    typedef struct packed {
        // raised by fetch
        logic fetchAddrErr;
        // raised by decode
        logic reservedInstr;
        logic syscall;
    } cp0Ctl_t;

    // fetch to decode, one slot
    typedef struct packed {
        logic    valid;
        instr_t  rawInstr;
        word_t   pc;
        // predictor guess and target
        logic    preB;
        word_t   prePc;
        cp0Ctl_t cp0Ctl;
    } fetchData_t;

    // decode output, one slot
    typedef struct packed {
        logic       valid;
        instr_t     rawInstr;
        word_t      pc;
        imm_t       imm;
        decodeCtl_t ctl;
        cp0Ctl_t    cp0Ctl;
        regAddr_t   ra1;
        regAddr_t   ra2;
        regAddr_t   rdst;
        cp0Addr_t   cp0ra;
        logic       preB;
        word_t      prePc;
    } decodeData_t;

endpackage
